//--- hdl/mrd_defs.svh
`ifndef MRD_DEFS_SVH
`define MRD_DEFS_SVH

// --------------------
// sample memory geometry
// --------------------

// banks, one per residue mod 7
`define MRD_NBANK 7
// words per bank
`define MRD_DEPTH 64
// bank word address
`define MRD_WADDR 6
// point address, N up to 448
`define MRD_WPT 9

// --------------------
// datapath
// --------------------

// real or imag part width
`define MRD_WD 18
// butterfly lanes, radix up to 5
`define MRD_NLANE 5

`endif

//--- hdl/mrd_pkg.sv
`include "mrd_defs.svh"

package mrd_pkg;

	// --------------------
	// sample and lane types
	// --------------------

	// one complex sample, 36 bits
	typedef struct packed {
		logic signed [`MRD_WD-1:0] re;
		logic signed [`MRD_WD-1:0] im;
	} cplx_t;

	// bank request of one lane
	// bank 7 means lane unused
	typedef struct packed {
		logic [2:0]            bank;
		logic [`MRD_WADDR-1:0] word;
	} bank_req_t;

	typedef bank_req_t [`MRD_NLANE-1:0] lane_reqs_t;

	// read stream towards the butterflies
	typedef struct packed {
		logic                         valid;
		logic [`MRD_NLANE-1:0]        mask;
		logic [2:0]                   factor;
		cplx_t [`MRD_NLANE-1:0]       lanes;
	} rd_stream_t;

	// --------------------
	// register map
	// --------------------

	localparam logic [3:0] REG_CTRL = 4'h0;
	localparam logic [3:0] REG_GEOM = 4'h4;
	localparam logic [3:0] REG_STAT = 4'h8;

	// control word, bit 0 start, bit 1 clear done
	typedef struct packed {
		logic [29:0] rsvd;
		logic        clr_done;
		logic        start;
	} ctrl_fields_t;

	// geometry word, factor in [2:0], N in [11:3]
	typedef struct packed {
		logic [19:0]         rsvd;
		logic [`MRD_WPT-1:0] npts;
		logic [2:0]          factor;
	} geom_fields_t;

	// same write word, decoded per address
	typedef union packed {
		logic [31:0]  word;
		ctrl_fields_t ctrl_f;
		geom_fields_t geom_f;
	} cfg_word_u;

endpackage

//--- hdl/mrd_cfg_regs.sv
`timescale 1ns/1ps
`include "mrd_defs.svh"

module mrd_cfg_regs
(
	input  logic                clk,
	input  logic                rst_n,

	// axi4-lite slave
	input  logic [3:0]          awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [31:0]         wdata,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [3:0]          araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [31:0]         rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,

	// stage control
	input  logic                busy,
	input  logic                rd_end,
	output logic                start,
	output logic [2:0]          factor,
	output logic [`MRD_WPT-1:0] npts
);

logic en_q;
logic aw_hold;
logic w_hold;
logic [3:0] waddr_q;
mrd_pkg::cfg_word_u wdata_q;
mrd_pkg::cfg_word_u rd_word;
logic done;

// one transaction at a time, write wins a tie
assign awready = en_q && !aw_hold;
assign wready  = en_q && !w_hold;
assign arready = en_q && !aw_hold && !w_hold && !awvalid && !wvalid;
assign rresp   = 2'b00;

// --------------------
// readback mux
// --------------------
always_comb
begin
	rd_word.word = '0;
	case (araddr)
		mrd_pkg::REG_GEOM:
		begin
			rd_word.geom_f.factor = factor;
			rd_word.geom_f.npts   = npts;
		end
		mrd_pkg::REG_STAT:
		begin
			rd_word.word[0] = busy;
			rd_word.word[1] = done;
		end
		default:
			rd_word.word = '0;
	endcase
end

// --------------------
// channel handshakes and register writes
// --------------------
always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		en_q    <= 1'b0;
		aw_hold <= 1'b0;
		w_hold  <= 1'b0;
		bvalid  <= 1'b0;
		bresp   <= 2'b00;
		rvalid  <= 1'b0;
		start   <= 1'b0;
		done    <= 1'b0;
		factor  <= '0;
		npts    <= '0;
	end
	else
	begin
		start <= 1'b0;
		// re-arm once nothing is pending
		if (!en_q && !bvalid && !rvalid && !aw_hold && !w_hold)
			en_q <= 1'b1;
		if (awvalid && awready)
		begin
			aw_hold <= 1'b1;
			waddr_q <= awaddr;
		end
		if (wvalid && wready)
		begin
			w_hold       <= 1'b1;
			wdata_q.word <= wdata;
		end
		// both halves in, commit and answer next cycle
		if (aw_hold && w_hold)
		begin
			aw_hold <= 1'b0;
			w_hold  <= 1'b0;
			en_q    <= 1'b0;
			bvalid  <= 1'b1;
			bresp   <= 2'b00;
			if (waddr_q == mrd_pkg::REG_CTRL)
			begin
				// start ignored while a stage runs
				if (wdata_q.ctrl_f.start && !busy)
				begin
					start <= 1'b1;
					done  <= 1'b0;
				end
				if (wdata_q.ctrl_f.clr_done)
					done <= 1'b0;
			end
			else if (waddr_q == mrd_pkg::REG_GEOM)
			begin
				if (busy)
					bresp <= 2'b10;
				else
				begin
					factor <= wdata_q.geom_f.factor;
					npts   <= wdata_q.geom_f.npts;
				end
			end
		end
		if (bvalid && bready)
			bvalid <= 1'b0;
		if (arvalid && arready)
		begin
			en_q   <= 1'b0;
			rvalid <= 1'b1;
			rdata  <= rd_word.word;
		end
		if (rvalid && rready)
			rvalid <= 1'b0;
		// end of stage sets done
		if (rd_end)
			done <= 1'b1;
	end
end

// write response out alone, nothing else in flight
a_one_xfer: assert property (@(posedge clk) disable iff (!rst_n)
	bvalid |-> !aw_hold && !w_hold && !rvalid);

endmodule

//--- hdl/mrd_rd_ctrl.sv
`timescale 1ns/1ps
`include "mrd_defs.svh"

module mrd_rd_ctrl
(
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 start,
	input  logic [2:0]                           factor,
	input  logic [`MRD_WPT-1:0]                  npts,
	output logic                                 issue,
	output logic [`MRD_WPT-1:0]                  group,
	output logic [`MRD_WPT-1:0]                  count,
	input  logic                                 addr_valid,
	input  logic [`MRD_NLANE-1:0]                lane_mask,
	input  mrd_pkg::cplx_t [`MRD_NLANE-1:0]      lanes,
	output mrd_pkg::rd_stream_t                  stream,
	output logic                                 rd_end,
	output logic                                 busy
);

typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_DRAIN} state_t;

state_t state;
logic div_run;
logic [`MRD_WPT-1:0] rem;
// stage 1 is addr_valid itself, these are stages 2 and 3
logic [1:0] v_q;
logic [1:0][`MRD_NLANE-1:0] mask_q;

assign busy  = (state != ST_IDLE);
assign issue = (state == ST_READ) && !div_run;

// --------------------
// fsm and group counter
// --------------------
always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		state   <= ST_IDLE;
		div_run <= 1'b0;
		group   <= '0;
		count   <= '0;
		v_q     <= '0;
		mask_q  <= '0;
		rd_end  <= 1'b0;
	end
	else
	begin
		v_q    <= {v_q[0], addr_valid};
		mask_q <= {mask_q[0], lane_mask};
		// last valid leaves the stream
		rd_end <= v_q[1] && !v_q[0];
		case (state)
			ST_IDLE:
				if (start)
				begin
					rem     <= npts;
					count   <= '0;
					div_run <= 1'b1;
					state   <= ST_READ;
				end
			ST_READ:
				if (div_run)
				begin
					// count = npts / factor, one subtraction per cycle
					if (factor != 3'd0 && rem >= `MRD_WPT'(factor))
					begin
						rem   <= rem - `MRD_WPT'(factor);
						count <= count + 1'b1;
					end
					else
					begin
						div_run <= 1'b0;
						group   <= '0;
						if (count == '0)
							state <= ST_IDLE;
					end
				end
				else
				begin
					group <= group + 1'b1;
					if (group == count - 1'b1)
						state <= ST_DRAIN;
				end
			ST_DRAIN:
				if (rd_end)
					state <= ST_IDLE;
			default:
				state <= ST_IDLE;
		endcase
	end
end

// output word, data straight from the banks
always_comb
begin
	stream.valid  = v_q[1];
	stream.mask   = mask_q[1];
	stream.factor = factor;
	stream.lanes  = lanes;
end

// issue never runs past the last group, and 3 cycles to the stream
a_issue_path: assert property (@(posedge clk) disable iff (!rst_n)
	issue |-> (group < count) ##1 addr_valid ##2 stream.valid);

endmodule

//--- hdl/mrd_butterfly_addr.sv
`timescale 1ns/1ps
`include "mrd_defs.svh"

module mrd_butterfly_addr
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   issue,
	input  logic [`MRD_WPT-1:0]                    group,
	input  logic [2:0]                             factor,
	input  logic [`MRD_WPT-1:0]                    count,
	output logic [`MRD_NLANE-1:0][`MRD_WPT-1:0]    addrs,
	output logic [`MRD_NLANE-1:0]                  lane_mask,
	output logic                                   addr_valid
);

// running sum group + j*count
logic [`MRD_NLANE-1:0][`MRD_WPT-1:0] sum;

// --------------------
// adder chain, no multiplier
// --------------------
always_comb
begin
	sum[0] = group;
	for (int j = 1; j < `MRD_NLANE; j++)
		sum[j] = sum[j-1] + count;
end

// control: valid and active lanes
always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		addr_valid <= 1'b0;
		lane_mask  <= '0;
	end
	else
	begin
		addr_valid <= issue;
		for (int j = 0; j < `MRD_NLANE; j++)
			lane_mask[j] <= issue && (3'(j) < factor);
	end
end

// point addresses
// lanes above the radix held at zero
always_ff @(posedge clk)
begin
	if (issue)
	begin
		for (int j = 0; j < `MRD_NLANE; j++)
			addrs[j] <= (3'(j) < factor) ? sum[j] : '0;
	end
end

endmodule

//--- hdl/mrd_bank_map.sv
`timescale 1ns/1ps
`include "mrd_defs.svh"

module mrd_bank_map
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [`MRD_NLANE-1:0][`MRD_WPT-1:0]    addrs,
	input  logic [`MRD_NLANE-1:0]                  lane_mask,
	output mrd_pkg::lane_reqs_t                    reqs
);

// quotient in the upper bits, remainder in [2:0]
logic [`MRD_NLANE-1:0][`MRD_WPT+2:0] qr;
logic clash;

// --------------------
// restoring divide by 7
// --------------------
function automatic logic [`MRD_WPT+2:0] div7(input logic [`MRD_WPT-1:0] a);
	logic [3:0] r;
	logic [`MRD_WPT-1:0] q;
	r = '0;
	q = '0;
	// msb first, one quotient bit per step
	for (int i = `MRD_WPT - 1; i >= 0; i--)
	begin
		r = {r[2:0], a[i]};
		if (r >= 4'd7)
		begin
			r    = r - 4'd7;
			q[i] = 1'b1;
		end
	end
	return {q, r[2:0]};
endfunction

for (genvar j = 0; j < `MRD_NLANE; j++)
begin : g_lane
	always_comb
		qr[j] = div7(addrs[j]);

	// remainder picks the bank, quotient the word
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			reqs[j].bank <= 3'd7;
		else
			reqs[j].bank <= lane_mask[j] ? qr[j][2:0] : 3'd7;
		reqs[j].word <= qr[j][`MRD_WADDR+2:3];
	end
end

// --------------------
// bank conflict check
// --------------------
always_comb
begin
	clash = 1'b0;
	for (int a = 0; a < `MRD_NLANE; a++)
		for (int b = a + 1; b < `MRD_NLANE; b++)
			if (reqs[a].bank != 3'd7 && reqs[a].bank == reqs[b].bank)
				clash = 1'b1;
end

// N not a multiple of 7 keeps the lanes of a group apart
a_no_clash: assert property (@(posedge clk) disable iff (!rst_n) !clash);

endmodule

//--- hdl/mrd_bank_mem.sv
`timescale 1ns/1ps
`include "mrd_defs.svh"

module mrd_bank_mem
(
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 load_valid,
	input  mrd_pkg::cplx_t                       load_data,
	input  logic                                 load_restart,
	input  logic                                 start,
	input  mrd_pkg::lane_reqs_t                  reqs,
	output mrd_pkg::cplx_t [`MRD_NLANE-1:0]      lanes
);

// load point n as bank n mod 7, word n div 7
logic [2:0] ld_bank;
logic [`MRD_WADDR-1:0] ld_word;
mrd_pkg::cplx_t bank_dout [`MRD_NBANK];
logic [`MRD_NLANE-1:0][2:0] bank_q;

// --------------------
// load counter
// --------------------
always_ff @(posedge clk)
begin
	if (!rst_n || start || load_restart)
	begin
		ld_bank <= '0;
		ld_word <= '0;
	end
	else if (load_valid)
	begin
		// wrap the bank, step the word
		if (ld_bank == 3'(`MRD_NBANK - 1))
		begin
			ld_bank <= '0;
			ld_word <= ld_word + 1'b1;
		end
		else
			ld_bank <= ld_bank + 1'b1;
	end
end

// --------------------
// banks
// --------------------
for (genvar b = 0; b < `MRD_NBANK; b++)
begin : g_bank
	mrd_pkg::cplx_t mem [`MRD_DEPTH];
	logic rd_hit;
	logic [`MRD_WADDR-1:0] rd_word;

	// the lane naming this bank
	always_comb
	begin
		rd_hit  = 1'b0;
		rd_word = '0;
		for (int j = 0; j < `MRD_NLANE; j++)
			if (reqs[j].bank == 3'(b))
			begin
				rd_hit  = 1'b1;
				rd_word = reqs[j].word;
			end
	end

	always_ff @(posedge clk)
	begin
		if (load_valid && ld_bank == 3'(b))
			mem[ld_word] <= load_data;
		if (rd_hit)
			bank_dout[b] <= mem[rd_word];
	end
end

// bank index follows the ram read by one cycle
always_ff @(posedge clk)
begin
	if (!rst_n)
		bank_q <= {`MRD_NLANE{3'd7}};
	else
		for (int j = 0; j < `MRD_NLANE; j++)
			bank_q[j] <= reqs[j].bank;
end

// lane crossbar, unused lanes read zero
always_comb
begin
	for (int j = 0; j < `MRD_NLANE; j++)
	begin
		lanes[j] = '0;
		if (bank_q[j] != 3'd7)
			lanes[j] = bank_dout[bank_q[j]];
	end
end

endmodule

//--- hdl/mrd_rd_top.sv
`timescale 1ns/1ps
`include "mrd_defs.svh"

module mrd_rd_top
(
	input  logic                clk,
	input  logic                rst_n,

	// axi4-lite slave
	input  logic [3:0]          awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [31:0]         wdata,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [3:0]          araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [31:0]         rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,

	// sequential load
	input  logic                load_valid,
	input  mrd_pkg::cplx_t      load_data,
	input  logic                load_restart,

	// read stream
	output mrd_pkg::rd_stream_t stream,
	output logic                rd_end
);

logic start;
logic busy;
logic [2:0] factor;
logic [`MRD_WPT-1:0] npts;
logic issue;
logic [`MRD_WPT-1:0] group;
logic [`MRD_WPT-1:0] count;
logic [`MRD_NLANE-1:0][`MRD_WPT-1:0] addrs;
logic [`MRD_NLANE-1:0] lane_mask;
logic addr_valid;
mrd_pkg::lane_reqs_t reqs;
mrd_pkg::cplx_t [`MRD_NLANE-1:0] lanes;

// --------------------
// registers
// --------------------
mrd_cfg_regs i_cfg_regs (
	.clk     (clk),     .rst_n   (rst_n),
	.awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
	.wdata   (wdata),   .wvalid  (wvalid),  .wready  (wready),
	.bresp   (bresp),   .bvalid  (bvalid),  .bready  (bready),
	.araddr  (araddr),  .arvalid (arvalid), .arready (arready),
	.rdata   (rdata),   .rresp   (rresp),   .rvalid  (rvalid),
	.rready  (rready),
	.busy    (busy),    .rd_end  (rd_end),  .start   (start),
	.factor  (factor),  .npts    (npts)
);

// --------------------
// read pipeline
// --------------------
mrd_rd_ctrl i_rd_ctrl (
	.clk        (clk),        .rst_n     (rst_n),
	.start      (start),      .factor    (factor),    .npts   (npts),
	.issue      (issue),      .group     (group),     .count  (count),
	.addr_valid (addr_valid), .lane_mask (lane_mask), .lanes  (lanes),
	.stream     (stream),     .rd_end    (rd_end),    .busy   (busy)
);

mrd_butterfly_addr i_butterfly_addr (
	.clk       (clk),       .rst_n (rst_n),
	.issue     (issue),     .group (group),  .factor     (factor),
	.count     (count),     .addrs (addrs),  .lane_mask  (lane_mask),
	.addr_valid (addr_valid)
);

mrd_bank_map i_bank_map (
	.clk       (clk),       .rst_n (rst_n),
	.addrs     (addrs),     .lane_mask (lane_mask),
	.reqs      (reqs)
);

mrd_bank_mem i_bank_mem (
	.clk          (clk),          .rst_n     (rst_n),
	.load_valid   (load_valid),   .load_data (load_data),
	.load_restart (load_restart), .start     (start),
	.reqs         (reqs),         .lanes     (lanes)
);

endmodule

//--- testbench/tb_mrd_rd.sv
`timescale 1ns/1ps
`include "mrd_defs.svh"

module tb_mrd_rd;

// four stages of well under a hundred cycles each
localparam int CYCLE_LIMIT = 20000;

logic clk;
logic rst_n;
logic [3:0] awaddr;
logic awvalid;
logic awready;
logic [31:0] wdata;
logic wvalid;
logic wready;
logic [1:0] bresp;
logic bvalid;
logic bready;
logic [3:0] araddr;
logic arvalid;
logic arready;
logic [31:0] rdata;
logic [1:0] rresp;
logic rvalid;
logic rready;
logic load_valid;
mrd_pkg::cplx_t load_data;
logic load_restart;
mrd_pkg::rd_stream_t stream;
logic rd_end;

// reference copy of the loaded points
mrd_pkg::cplx_t model [`MRD_NBANK * `MRD_DEPTH];
mrd_pkg::rd_stream_t got_q [$];
int end_count = 0;
logic prev_valid = 1'b0;
int value_errors = 0;
int other_errors = 0;
int cycles = 0;

mrd_rd_top i_dut (
	.clk (clk), .rst_n (rst_n),
	.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
	.wdata (wdata), .wvalid (wvalid), .wready (wready),
	.bresp (bresp), .bvalid (bvalid), .bready (bready),
	.araddr (araddr), .arvalid (arvalid), .arready (arready),
	.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
	.load_valid (load_valid), .load_data (load_data), .load_restart (load_restart),
	.stream (stream), .rd_end (rd_end)
);

initial
begin
	clk = 1'b0;
	forever
		#10 clk = ~clk;
end

// --------------------
// watchdog
// --------------------
always @(posedge clk)
begin
	cycles++;
	if (cycles >= CYCLE_LIMIT)
	begin
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		$display("RESULT: FAIL");
		$finish;
	end
end

// stream monitor, sampled mid-cycle
always @(negedge clk)
begin
	if (rst_n)
	begin
		if (stream.valid)
			got_q.push_back(stream);
		if (rd_end)
		begin
			end_count++;
			// pulse belongs right after the last valid word
			if (stream.valid || !prev_valid)
			begin
				$display("rd_end pulse did not follow the last valid output");
				other_errors++;
			end
		end
		prev_valid = stream.valid;
	end
end

// --------------------
// helpers
// --------------------
task automatic step();
	@(posedge clk);
	#2;
endtask

task automatic report_mismatch(input string name, input logic [63:0] got,
	input logic [63:0] exp);
	$display("FAILED %s: got %0h, expected %0h", name, got, exp);
	value_errors++;
endtask

// factor in [2:0], N in [11:3]
function automatic logic [31:0] geom_word(input logic [2:0] fac, input int n);
	return {20'd0, 9'(n), fac};
endfunction

task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
	output logic [1:0] resp);
	logic aw_fire;
	logic w_fire;
	awaddr  = addr;
	awvalid = 1'b1;
	wdata   = data;
	wvalid  = 1'b1;
	bready  = 1'b1;
	// aw and w may be taken on different cycles
	while (awvalid || wvalid)
	begin
		aw_fire = awvalid && awready;
		w_fire  = wvalid && wready;
		step();
		if (aw_fire)
			awvalid = 1'b0;
		if (w_fire)
			wvalid = 1'b0;
	end
	while (!bvalid)
		step();
	resp = bresp;
	step();
	bready = 1'b0;
endtask

task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
	output logic [1:0] resp);
	logic ar_fire;
	araddr  = addr;
	arvalid = 1'b1;
	rready  = 1'b1;
	while (arvalid)
	begin
		ar_fire = arready;
		step();
		if (ar_fire)
			arvalid = 1'b0;
	end
	while (!rvalid)
		step();
	data = rdata;
	resp = rresp;
	step();
	rready = 1'b0;
endtask

// points 0 to n-1, random data
task automatic load_points(input int n);
	load_restart = 1'b1;
	step();
	load_restart = 1'b0;
	for (int i = 0; i < n; i++)
	begin
		model[i]   = 36'({$urandom, $urandom});
		load_valid = 1'b1;
		load_data  = model[i];
		step();
	end
	load_valid = 1'b0;
endtask

// --------------------
// one stage, end to end
// --------------------
task automatic run_stage(input logic [2:0] fac, input int n, input bit poke_busy);
	logic [1:0] resp;
	logic [31:0] rd;
	int cnt;
	int base;
	mrd_pkg::rd_stream_t s;
	logic [`MRD_NLANE-1:0] exp_mask;
	mrd_pkg::cplx_t exp_lane;
	cnt      = n / int'(fac);
	exp_mask = 5'((1 << fac) - 1);
	axi_write(mrd_pkg::REG_GEOM, geom_word(fac, n), resp);
	if (resp != 2'b00)
		report_mismatch("bresp geom", 64'(resp), 64'(2'b00));
	load_points(n);
	got_q.delete();
	base = end_count;
	axi_write(mrd_pkg::REG_CTRL, 32'h1, resp);
	if (resp != 2'b00)
		report_mismatch("bresp ctrl", 64'(resp), 64'(2'b00));
	// geometry locked while the stage runs
	if (poke_busy)
	begin
		axi_write(mrd_pkg::REG_GEOM, geom_word(3'd5, 20), resp);
		if (resp != 2'b10)
			report_mismatch("bresp geom busy", 64'(resp), 64'(2'b10));
	end
	while (end_count == base)
		step();
	repeat (4)
		step();
	if (end_count != base + 1)
	begin
		$display("expected one rd_end pulse in the stage, saw %0d", end_count - base);
		other_errors++;
	end
	if (got_q.size() != cnt)
		report_mismatch("stream valid count", 64'(got_q.size()), 64'(cnt));
	// lane j of group g is point g + j*count
	for (int g = 0; g < got_q.size() && g < cnt; g++)
	begin
		s = got_q[g];
		if (s.mask != exp_mask)
			report_mismatch($sformatf("stream.mask group %0d", g), 64'(s.mask),
				64'(exp_mask));
		if (s.factor != fac)
			report_mismatch($sformatf("stream.factor group %0d", g), 64'(s.factor),
				64'(fac));
		for (int j = 0; j < `MRD_NLANE; j++)
		begin
			exp_lane = (j < int'(fac)) ? model[g + j * cnt] : '0;
			if (s.lanes[j] != exp_lane)
				report_mismatch($sformatf("stream.lanes[%0d] group %0d", j, g),
					64'(s.lanes[j]), 64'(exp_lane));
		end
	end
	axi_read(mrd_pkg::REG_GEOM, rd, resp);
	if (rd != geom_word(fac, n))
		report_mismatch("rdata geom", 64'(rd), 64'(geom_word(fac, n)));
	// done up, busy down
	axi_read(mrd_pkg::REG_STAT, rd, resp);
	if (rd != 32'h2)
		report_mismatch("rdata stat after stage", 64'(rd), 64'(32'h2));
	axi_write(mrd_pkg::REG_CTRL, 32'h2, resp);
	axi_read(mrd_pkg::REG_STAT, rd, resp);
	if (rd != 32'h0)
		report_mismatch("rdata stat after clear", 64'(rd), 64'(32'h0));
endtask

// --------------------
// test sequence
// --------------------
initial
begin
	logic [31:0] rd;
	logic [1:0] resp;
	void'($urandom(32'h66251e6e));
	rst_n        = 1'b0;
	awaddr       = '0;
	awvalid      = 1'b0;
	wdata        = '0;
	wvalid       = 1'b0;
	bready       = 1'b0;
	araddr       = '0;
	arvalid      = 1'b0;
	rready       = 1'b0;
	load_valid   = 1'b0;
	load_data    = '0;
	load_restart = 1'b0;
	repeat (5)
		@(posedge clk);
	#2;
	// outputs quiet under reset
	if (stream.valid)
		report_mismatch("stream.valid", 64'(stream.valid), 64'(0));
	if (rd_end)
		report_mismatch("rd_end", 64'(rd_end), 64'(0));
	if (bvalid || rvalid)
		report_mismatch("bvalid|rvalid", 64'({bvalid, rvalid}), 64'(0));
	if (awready || wready || arready)
		report_mismatch("awready|wready|arready", 64'({awready, wready, arready}),
			64'(0));
	rst_n = 1'b1;
	step();
	axi_read(mrd_pkg::REG_STAT, rd, resp);
	if (rd != 32'h0)
		report_mismatch("rdata stat after reset", 64'(rd), 64'(0));

	// geometry readback
	axi_write(mrd_pkg::REG_GEOM, geom_word(3'd5, 20), resp);
	if (resp != 2'b00)
		report_mismatch("bresp geom", 64'(resp), 64'(0));
	axi_read(mrd_pkg::REG_GEOM, rd, resp);
	if (resp != 2'b00)
		report_mismatch("rresp geom", 64'(resp), 64'(0));
	if (rd != geom_word(3'd5, 20))
		report_mismatch("rdata geom", 64'(rd), 64'(geom_word(3'd5, 20)));

	// full radix, then partial lanes
	run_stage(3'd5, 20, 1'b0);
	run_stage(3'd3, 12, 1'b0);
	run_stage(3'd2, 8, 1'b0);
	// geometry write during a longer stage
	run_stage(3'd3, 30, 1'b1);

	$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
	if (value_errors + other_errors == 0)
		$display("RESULT: PASS");
	else
		$display("RESULT: FAIL");
	$finish;
end

endmodule

//--- tb.f
+incdir+hdl
hdl/mrd_pkg.sv
hdl/mrd_cfg_regs.sv
hdl/mrd_rd_ctrl.sv
hdl/mrd_butterfly_addr.sv
hdl/mrd_bank_map.sv
hdl/mrd_bank_mem.sv
hdl/mrd_rd_top.sv
testbench/tb_mrd_rd.sv

//--- run_sim.sh
#!/bin/bash
# build and run the read-side testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module tb_mrd_rd \
	-f tb.f \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "RESULT: PASS" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
